// ==== icache_top.f ====
+incdir+.
verilog/icache_pkg.sv
verilog/cache_ram.sv
verilog/i_cache.sv
verilog/icache_ctrl_regs.sv
verilog/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_icache_top \
    -f icache_top.f \
    -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log" >&2
    exit 1
fi

// ==== sim/tb_icache_top.sv ====
`timescale 1ns/10ps
`include "icache_config.svh"

module tb_icache_top;

    localparam int NUM_TESTS   = 6;
    localparam int CLK_PERIOD  = 20;
    localparam int FETCH_LIMIT = 200;    // cycles to wait for inst_valid
    localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;

    // A, B and C share index 0x10
    localparam logic [31:0] ADDR_A = 32'h0000_1040;
    localparam logic [31:0] ADDR_B = 32'h0000_2040;
    localparam logic [31:0] ADDR_C = 32'h0000_3040;
    localparam logic [31:0] ADDR_M = 32'h0000_0100;
    localparam logic [31:0] ADDR_X = 32'h0000_0200;
    localparam logic [31:0] ADDR_Y = 32'h0000_0300;
    localparam logic [31:0] ADDR_Z = 32'h0000_0400;

    logic                      clk;
    logic                      rst;
    logic                      inst_en;
    logic [`ICACHE_ADDR_W-1:0] pc_next;
    logic [`ICACHE_ADDR_W-1:0] pcF;
    logic [`ICACHE_DATA_W-1:0] inst_rdata;
    logic                      stall;
    logic                      hit;
    logic                      inst_valid;
    icache_pkg::ar_req_t       ar;
    logic                      arvalid;
    logic                      arready;
    icache_pkg::r_beat_t       r;
    logic                      rvalid;
    logic                      rready;
    logic                      reg_wr;
    logic                      reg_rd;
    icache_pkg::reg_addr_t     reg_addr;
    logic [`ICACHE_DATA_W-1:0] reg_wdata;
    logic [`ICACHE_DATA_W-1:0] reg_rdata;

    int req_count;
    int len_errors;
    int errors;
    int tests_failed;
    int exp_hits;       // expected counter values from the test sequence
    int exp_misses;
    logic [31:0] rng;
    icache_pkg::cache_state_t dut_state;

    assign dut_state = DUT.u_i_cache.state;   // for timeout messages

    icache_top DUT (.*);

    tb_mem_model u_mem (
        .clk, .rst, .ar, .arvalid, .arready, .r, .rvalid, .rready,
        .req_count, .len_errors
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 3000 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run is stuck in state %s",
                 NUM_TESTS * 3000, dut_state.name());
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got 0x%h, expected 0x%h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    task automatic reg_write(input icache_pkg::reg_addr_t addr, input logic [31:0] data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(posedge clk);
        #2;
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input icache_pkg::reg_addr_t addr, output logic [31:0] data);
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(posedge clk);
        #2;
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    // exp_hit is 1 for a hit, 0 for a miss and -1 to check the data only
    task automatic fetch(input logic [31:0] addr, input int exp_hit);
        int          req_before;
        int          waited;
        logic        seen;
        logic        hit_seen;
        logic        stall_seen;
        logic [31:0] data_seen;
        req_before = req_count;
        waited     = 0;
        seen       = 1'b0;
        hit_seen   = 1'b0;
        stall_seen = 1'b0;
        data_seen  = '0;
        while (stall) begin
            @(posedge clk);
            #2;
        end
        pc_next = addr;
        pcF     = addr;
        repeat (2) @(posedge clk);     // let an IDLE read pick up the new index
        #2;
        inst_en = 1'b1;
        while (!seen && waited < FETCH_LIMIT) begin
            @(negedge clk);
            if (inst_valid) begin
                seen       = 1'b1;
                hit_seen   = hit;
                stall_seen = stall;    // high in REFILL and low on a hit
                data_seen  = inst_rdata;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        #2;
        inst_en = 1'b0;
        assert (seen) else begin
            $display("fetch of %h got no inst_valid within %0d cycles, cache in state %s",
                     addr, FETCH_LIMIT, dut_state.name());
            errors++;
        end
        if (seen) begin
            check_eq("inst_rdata", data_seen, addr ^ DATA_KEY);
            check_eq("stall", 32'(stall), 32'h0);    // back in IDLE
            if (exp_hit >= 0) begin
                check_eq("hit", 32'(hit_seen), 32'(exp_hit));
                check_eq("stall", 32'(stall_seen), (exp_hit == 0) ? 32'd1 : 32'd0);
                check_eq("memory requests", 32'(req_count - req_before),
                         (exp_hit == 1) ? 32'd0 : 32'd1);
            end
        end
        if (exp_hit == 1) begin
            exp_hits++;
        end else if (exp_hit == 0) begin
            exp_misses++;
        end
    endtask

    task automatic test_miss_then_hit();
        int err0;
        err0 = errors;
        reg_write(icache_pkg::REG_CTRL, 32'h1);
        fetch(ADDR_M, 0);
        fetch(ADDR_M, 1);
        report_test("miss then hit", err0);
    endtask

    task automatic test_lru_replace();
        int err0;
        err0 = errors;
        fetch(ADDR_A, 0);
        fetch(ADDR_B, 0);
        fetch(ADDR_C, 0);   // A is least recent
        fetch(ADDR_A, 0);   // B is least recent now
        fetch(ADDR_C, 1);
        fetch(ADDR_B, 0);
        report_test("lru replacement", err0);
    endtask

    task automatic test_counters();
        int          err0;
        logic [31:0] rd;
        err0 = errors;
        reg_write(icache_pkg::REG_HITS, 32'h0);
        reg_write(icache_pkg::REG_MISSES, 32'h0);
        exp_hits   = 0;
        exp_misses = 0;
        fetch(ADDR_X, 0);
        fetch(ADDR_X, 1);
        fetch(ADDR_X, 1);
        fetch(ADDR_Y, 0);
        fetch(ADDR_Y, 1);
        fetch(ADDR_X, 1);
        reg_read(icache_pkg::REG_HITS, rd);
        check_eq("HITS", rd, 32'(exp_hits));
        reg_read(icache_pkg::REG_MISSES, rd);
        check_eq("MISSES", rd, 32'(exp_misses));
        reg_write(icache_pkg::REG_HITS, 32'h0);
        reg_read(icache_pkg::REG_HITS, rd);
        check_eq("HITS", rd, 32'h0);
        reg_read(icache_pkg::REG_MISSES, rd);
        check_eq("MISSES", rd, 32'(exp_misses));   // untouched by the HITS clear
        report_test("statistics counters", err0);
    endtask

    task automatic test_flush();
        int          err0;
        int          polls;
        logic        busy_seen;
        logic [31:0] rd;
        logic [31:0] kept [5];
        err0 = errors;
        kept = '{ADDR_M, ADDR_B, ADDR_C, ADDR_X, ADDR_Y};
        foreach (kept[i]) begin
            fetch(kept[i], 1);
        end
        reg_write(icache_pkg::REG_CTRL, 32'h3);
        busy_seen = 1'b0;
        polls     = 0;
        rd        = '0;
        while (!busy_seen && polls < 10) begin
            reg_read(icache_pkg::REG_STATUS, rd);
            busy_seen = rd[0];
            polls++;
        end
        assert (busy_seen) else begin
            $display("STATUS never showed the flush as busy");
            errors++;
        end
        polls = 0;
        while (rd[0] && polls < 2 * `ICACHE_SETS) begin
            reg_read(icache_pkg::REG_STATUS, rd);
            polls++;
        end
        assert (!rd[0]) else begin
            $display("flush still busy after %0d STATUS reads", polls);
            errors++;
        end
        reg_read(icache_pkg::REG_CTRL, rd);
        check_eq("CTRL", rd, 32'h1);    // flush bit gone and enable kept
        foreach (kept[i]) begin
            fetch(kept[i], 0);
        end
        report_test("flush", err0);
    endtask

    task automatic test_bypass();
        int err0;
        err0 = errors;
        reg_write(icache_pkg::REG_CTRL, 32'h0);
        repeat (3) fetch(ADDR_Z, 0);
        fetch(ADDR_M, 0);   // cached but bypassed
        reg_write(icache_pkg::REG_CTRL, 32'h1);
        fetch(ADDR_Z, 0);
        fetch(ADDR_Z, 1);
        report_test("bypass when disabled", err0);
    endtask

    task automatic test_back_pressure();
        int          err0;
        int          req0;
        logic [31:0] rd;
        logic [31:0] addrs [8];
        err0 = errors;
        // four tags over indexes 0..3 so sets overflow
        for (int i = 0; i < 8; i++) begin
            rng      = next_rand(rng);
            addrs[i] = 32'h0010_0000 | {18'b0, rng[21:20], 8'b0, rng[25:24], 2'b0};
        end
        reg_write(icache_pkg::REG_MISSES, 32'h0);
        req0 = req_count;
        for (int n = 0; n < 40; n++) begin
            rng = next_rand(rng);
            fetch(addrs[rng[18:16]], -1);
        end
        reg_read(icache_pkg::REG_MISSES, rd);
        check_eq("MISSES", rd, 32'(req_count - req0));
        report_test("back-pressure stream", err0);
    endtask

    initial begin
        int waited;
        rst          = 1'b1;
        inst_en      = 1'b0;
        pc_next      = '0;
        pcF          = '0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = icache_pkg::REG_CTRL;
        reg_wdata    = '0;
        errors       = 0;
        tests_failed = 0;
        exp_hits     = 0;
        exp_misses   = 0;
        rng          = 32'd70130;
        repeat (10) @(posedge clk);
        #2;
        rst    = 1'b0;
        waited = 0;
        while (DUT.flush_busy && waited < 2 * `ICACHE_SETS) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (!DUT.flush_busy) else begin
            $display("reset flush still running after %0d cycles", waited);
            errors++;
        end

        test_miss_then_hit();
        test_lru_replace();
        test_counters();
        test_flush();
        test_bypass();
        test_back_pressure();

        check_eq("memory len errors", 32'(len_errors), 32'h0);
        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/10ps
`include "icache_config.svh"

// read-only memory slave, one beat per request, random wait states
module tb_mem_model #(
    parameter logic [31:0] SEED      = 32'd70130,
    parameter int          MAX_DELAY = 5
) (
    input  logic                clk,
    input  logic                rst,
    input  icache_pkg::ar_req_t ar,
    input  logic                arvalid,
    output logic                arready,
    output icache_pkg::r_beat_t r,
    output logic                rvalid,
    input  logic                rready,
    output int                  req_count,   // accepted addresses
    output int                  len_errors
);

    localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;

    logic [31:0] rng;
    logic [31:0] addr_q;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int  delay;
        logic taken;
        arready    = 1'b0;
        rvalid     = 1'b0;
        r          = '0;
        req_count  = 0;
        len_errors = 0;
        rng        = SEED;
        addr_q     = '0;
        forever begin
            @(posedge clk);
            #2;
            if (!rst && arvalid) begin
                addr_q = ar.addr;
                if (ar.len != '0) begin
                    $display("memory model: read of %h asked for len %0d, not a single beat",
                             ar.addr, ar.len);
                    len_errors++;
                end
                rng   = next_rand(rng);
                delay = int'(rng[23:16]) % (MAX_DELAY + 1);
                wait_cycles(delay);
                arready = 1'b1;
                @(posedge clk);     // arvalid held high, so the address goes here
                #2;
                arready = 1'b0;
                req_count++;
                rng   = next_rand(rng);
                delay = int'(rng[23:16]) % (MAX_DELAY + 1);
                wait_cycles(delay);
                r      = '{data: addr_q ^ DATA_KEY, last: 1'b1};
                rvalid = 1'b1;
                taken  = 1'b0;
                while (!taken) begin
                    taken = rready;     // registered, so this is its value at the edge
                    @(posedge clk);
                    #2;
                end
                rvalid = 1'b0;
                r      = '0;
            end
        end
    end

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    // fetch stage
    input  logic                      inst_en,
    input  logic [`ICACHE_ADDR_W-1:0] pc_next,
    input  logic [`ICACHE_ADDR_W-1:0] pcF,
    output logic [`ICACHE_DATA_W-1:0] inst_rdata,
    output logic                      stall,
    output logic                      hit,
    output logic                      inst_valid,
    // memory read channel
    output icache_pkg::ar_req_t       ar,
    output logic                      arvalid,
    input  logic                      arready,
    input  icache_pkg::r_beat_t       r,
    input  logic                      rvalid,
    output logic                      rready,
    // host registers
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  icache_pkg::reg_addr_t     reg_addr,
    input  logic [`ICACHE_DATA_W-1:0] reg_wdata,
    output logic [`ICACHE_DATA_W-1:0] reg_rdata
);

    localparam int TAG_RAM_W = $bits(icache_pkg::tag_entry_t);

    logic cache_en;
    logic flush_req;
    logic flush_busy;
    logic hit_pulse;
    logic miss_pulse;
    logic way0_tag_en;
    logic way1_tag_en;
    logic way0_we;
    logic way1_we;

    logic [`ICACHE_INDEX_W-1:0] ram_addr;
    logic [`ICACHE_DATA_W-1:0]  data_wdata;
    logic [`ICACHE_DATA_W-1:0]  way0_data;
    logic [`ICACHE_DATA_W-1:0]  way1_data;
    icache_pkg::tag_entry_t     tag_wdata;
    icache_pkg::tag_entry_t     way0_tag;
    icache_pkg::tag_entry_t     way1_tag;

    i_cache u_i_cache (.*);

    icache_ctrl_regs u_ctrl_regs (.*);

    // tag and data rams share enable and write strobe per way
    cache_ram #(.WIDTH(TAG_RAM_W), .DEPTH_LOG2(`ICACHE_INDEX_W)) u_tag_way0 (
        .clk, .en(way0_tag_en), .we(way0_we),
        .addr(ram_addr), .din(tag_wdata), .dout(way0_tag)
    );

    cache_ram #(.WIDTH(TAG_RAM_W), .DEPTH_LOG2(`ICACHE_INDEX_W)) u_tag_way1 (
        .clk, .en(way1_tag_en), .we(way1_we),
        .addr(ram_addr), .din(tag_wdata), .dout(way1_tag)
    );

    cache_ram #(.WIDTH(`ICACHE_DATA_W), .DEPTH_LOG2(`ICACHE_INDEX_W)) u_data_way0 (
        .clk, .en(way0_tag_en), .we(way0_we),
        .addr(ram_addr), .din(data_wdata), .dout(way0_data)
    );

    cache_ram #(.WIDTH(`ICACHE_DATA_W), .DEPTH_LOG2(`ICACHE_INDEX_W)) u_data_way1 (
        .clk, .en(way1_tag_en), .we(way1_we),
        .addr(ram_addr), .din(data_wdata), .dout(way1_data)
    );

endmodule

// ==== verilog/icache_ctrl_regs.sv ====
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_ctrl_regs (
    input  logic                      clk,
    input  logic                      rst,
    // host register port
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  icache_pkg::reg_addr_t     reg_addr,
    input  logic [`ICACHE_DATA_W-1:0] reg_wdata,
    output logic [`ICACHE_DATA_W-1:0] reg_rdata,
    // cache side
    output logic                      cache_en,
    output logic                      flush_req,
    input  logic                      flush_busy,
    input  logic                      hit_pulse,
    input  logic                      miss_pulse
);

    localparam int PAD_W = `ICACHE_DATA_W - `ICACHE_COUNT_W;

    logic [`ICACHE_COUNT_W-1:0] hits;
    logic [`ICACHE_COUNT_W-1:0] misses;

    logic wr_ctrl;
    logic wr_hits;
    logic wr_misses;

    assign wr_ctrl   = reg_wr && (reg_addr == icache_pkg::REG_CTRL);
    assign wr_hits   = reg_wr && (reg_addr == icache_pkg::REG_HITS);
    assign wr_misses = reg_wr && (reg_addr == icache_pkg::REG_MISSES);

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_en  <= 1'b0;
            flush_req <= 1'b0;
        end else begin
            flush_req <= wr_ctrl && reg_wdata[1];   // self clearing
            if (wr_ctrl) begin
                cache_en <= reg_wdata[0];
            end
        end
    end

    // saturating counters, a write clears
    always_ff @(posedge clk) begin
        if (rst) begin
            hits   <= '0;
            misses <= '0;
        end else begin
            if (wr_hits) begin
                hits <= '0;
            end else if (hit_pulse && !(&hits)) begin
                hits <= hits + 1'b1;
            end

            if (wr_misses) begin
                misses <= '0;
            end else if (miss_pulse && !(&misses)) begin
                misses <= misses + 1'b1;
            end
        end
    end

    // read data one cycle after reg_rd
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_addr)
                icache_pkg::REG_CTRL:   reg_rdata <= {{(`ICACHE_DATA_W-1){1'b0}}, cache_en};
                icache_pkg::REG_STATUS: reg_rdata <= {{(`ICACHE_DATA_W-1){1'b0}}, flush_busy};
                icache_pkg::REG_HITS:   reg_rdata <= {{PAD_W{1'b0}}, hits};
                icache_pkg::REG_MISSES: reg_rdata <= {{PAD_W{1'b0}}, misses};
                default:                reg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/i_cache.sv ====
`timescale 1ns/10ps
`include "icache_config.svh"

module i_cache (
    input  logic                       clk,
    input  logic                       rst,
    // fetch stage
    input  logic                       inst_en,
    input  logic [`ICACHE_ADDR_W-1:0]  pc_next,
    input  logic [`ICACHE_ADDR_W-1:0]  pcF,
    output logic [`ICACHE_DATA_W-1:0]  inst_rdata,
    output logic                       stall,
    output logic                       hit,
    output logic                       inst_valid,
    // memory read channel
    output icache_pkg::ar_req_t        ar,
    output logic                       arvalid,
    input  logic                       arready,
    input  icache_pkg::r_beat_t        r,
    input  logic                       rvalid,
    output logic                       rready,
    // control and statistics
    input  logic                       cache_en,
    input  logic                       flush_req,
    output logic                       flush_busy,
    output logic                       hit_pulse,
    output logic                       miss_pulse,
    // way rams
    output logic                       way0_tag_en,
    output logic                       way1_tag_en,
    output logic                       way0_we,
    output logic                       way1_we,
    output logic [`ICACHE_INDEX_W-1:0] ram_addr,
    output icache_pkg::tag_entry_t     tag_wdata,
    output logic [`ICACHE_DATA_W-1:0]  data_wdata,
    input  icache_pkg::tag_entry_t     way0_tag,
    input  icache_pkg::tag_entry_t     way1_tag,
    input  logic [`ICACHE_DATA_W-1:0]  way0_data,
    input  logic [`ICACHE_DATA_W-1:0]  way1_data
);

    localparam int IDX_LO = `ICACHE_OFFSET_W;
    localparam int IDX_HI = `ICACHE_OFFSET_W + `ICACHE_INDEX_W - 1;

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t state_nxt;

    logic [`ICACHE_TAG_W-1:0]   pc_tag;
    logic [`ICACHE_INDEX_W-1:0] pc_index;
    logic [`ICACHE_INDEX_W-1:0] next_index;
    logic [`ICACHE_INDEX_W-1:0] flush_cnt;
    logic [`ICACHE_SETS-1:0]    lru;        // per set, 1 means way1 goes next
    logic [`ICACHE_DATA_W-1:0]  line_q;     // refill word

    logic hit0;
    logic hit1;
    logic way_hit;
    logic lookup;
    logic victim;
    logic fill;
    logic req_pend;     // address not yet accepted
    logic addr_acc;     // address accepted, waiting for data
    logic last_beat;
    logic flush_pend;   // flush asked for outside IDLE

    assign pc_tag     = pcF[`ICACHE_ADDR_W-1:IDX_HI+1];
    assign pc_index   = pcF[IDX_HI:IDX_LO];
    assign next_index = pc_next[IDX_HI:IDX_LO];

    // tag compare against the word read in IDLE
    assign hit0    = way0_tag.valid && (way0_tag.tag == pc_tag);
    assign hit1    = way1_tag.valid && (way1_tag.tag == pc_tag);
    assign way_hit = cache_en && (hit0 || hit1);   // disabled cache never hits
    assign lookup  = (state == icache_pkg::HIT_JUDGE) && inst_en;

    assign victim    = lru[pc_index];
    assign fill      = (state == icache_pkg::REFILL) && cache_en;
    assign last_beat = rvalid && rready && r.last;

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::IDLE: begin
                if (flush_req || flush_pend) begin
                    state_nxt = icache_pkg::FLUSH;
                end else begin
                    state_nxt = icache_pkg::HIT_JUDGE;
                end
            end
            icache_pkg::HIT_JUDGE: begin
                if (lookup && !way_hit) begin
                    state_nxt = icache_pkg::LOAD_MEM;
                end else begin
                    state_nxt = icache_pkg::IDLE;
                end
            end
            icache_pkg::LOAD_MEM: begin
                if (last_beat) begin
                    state_nxt = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: state_nxt = icache_pkg::IDLE;   // one write cycle
            icache_pkg::FLUSH: begin
                if (&flush_cnt) begin
                    state_nxt = icache_pkg::IDLE;
                end
            end
            default: state_nxt = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= icache_pkg::FLUSH;  // walk the rams after reset
            flush_cnt  <= '0;
            flush_pend <= 1'b0;
            req_pend   <= 1'b0;
            addr_acc   <= 1'b0;
            lru        <= '0;
        end else begin
            state <= state_nxt;

            if (state == icache_pkg::FLUSH) begin
                flush_cnt <= flush_cnt + 1'b1;    // wraps back to 0 at the end
            end

            if (state == icache_pkg::IDLE) begin
                flush_pend <= 1'b0;
            end else if (flush_req && state != icache_pkg::FLUSH) begin
                flush_pend <= 1'b1;
            end

            // one single-beat read per miss
            if (lookup && !way_hit) begin
                req_pend <= 1'b1;
            end else if (arvalid && arready) begin
                req_pend <= 1'b0;
            end

            if (arvalid && arready) begin
                addr_acc <= 1'b1;
            end else if (last_beat) begin
                addr_acc <= 1'b0;
            end

            if (state == icache_pkg::FLUSH) begin
                lru <= '0;
            end else if (hit) begin
                lru[pc_index] <= ~hit1;       // point at the way not used
            end else if (fill) begin
                lru[pc_index] <= ~victim;     // away from the way just written
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            line_q <= r.data;
        end
    end

    // ram address and strobes
    always_comb begin
        ram_addr    = pc_index;
        way0_tag_en = 1'b0;
        way1_tag_en = 1'b0;
        way0_we     = 1'b0;
        way1_we     = 1'b0;
        tag_wdata   = '{tag: pc_tag, valid: 1'b1};
        case (state)
            icache_pkg::IDLE: begin
                ram_addr    = next_index;     // lookup read for the next cycle
                way0_tag_en = 1'b1;
                way1_tag_en = 1'b1;
            end
            icache_pkg::FLUSH: begin
                ram_addr    = flush_cnt;
                way0_tag_en = 1'b1;
                way1_tag_en = 1'b1;
                way0_we     = 1'b1;
                way1_we     = 1'b1;
                tag_wdata   = '0;             // invalid entry
            end
            icache_pkg::REFILL: begin
                way0_tag_en = fill && !victim;
                way1_tag_en = fill && victim;
                way0_we     = fill && !victim;
                way1_we     = fill && victim;
            end
            default: ;
        endcase
    end

    assign data_wdata = line_q;

    assign ar      = '{addr: pcF, len: '0};
    assign arvalid = req_pend;
    assign rready  = addr_acc;

    assign hit        = lookup && way_hit;
    assign inst_valid = hit || (state == icache_pkg::REFILL);
    assign inst_rdata = (state == icache_pkg::HIT_JUDGE) ? (hit1 ? way1_data : way0_data)
                                                         : line_q;
    assign stall      = state inside {icache_pkg::LOAD_MEM, icache_pkg::REFILL,
                                      icache_pkg::FLUSH};
    assign flush_busy = (state == icache_pkg::FLUSH);
    assign hit_pulse  = hit;
    assign miss_pulse = lookup && !way_hit;

endmodule

// ==== verilog/cache_ram.sv ====
`timescale 1ns/10ps

// single port synchronous ram, read-first on write
module cache_ram #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [DEPTH_LOG2-1:0] addr,
    input  logic [WIDTH-1:0]      din,
    output logic [WIDTH-1:0]      dout
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            dout <= mem[addr];      // old word, also on a write
            if (we) begin
                mem[addr] <= din;
            end
        end
    end

    // dout holds its last value while en is low

endmodule

// ==== verilog/icache_pkg.sv ====
`include "icache_config.svh"

package icache_pkg;

    // cache controller states
    typedef enum logic [2:0] {
        IDLE,
        HIT_JUDGE,
        LOAD_MEM,
        REFILL,
        FLUSH
    } cache_state_t;

    // control/status register map
    typedef enum logic [1:0] {
        REG_CTRL,       // bit0 enable, bit1 flush (write one)
        REG_STATUS,     // bit0 flush busy
        REG_HITS,
        REG_MISSES
    } reg_addr_t;

    // tag ram word
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic                     valid;
    } tag_entry_t;

    // read address payload
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [`ICACHE_LEN_W-1:0]  len;
    } ar_req_t;

    // read data payload
    typedef struct packed {
        logic [`ICACHE_DATA_W-1:0] data;
        logic                      last;
    } r_beat_t;

endpackage

// ==== icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch address and instruction word
`define ICACHE_ADDR_W   32
`define ICACHE_DATA_W   32

// pc split: tag | index | offset
`define ICACHE_OFFSET_W 2
`define ICACHE_INDEX_W  10
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// number of sets, one LRU bit each
`define ICACHE_SETS     (1 << `ICACHE_INDEX_W)

// read channel burst length field
`define ICACHE_LEN_W    8

// hit and miss statistics counters
`define ICACHE_COUNT_W  16

`endif
